//--- Bender.yml
package:
  name: pipe_core

sources:
  - hdl/isaPkg.sv
  - hdl/corePkg.sv
  - hdl/registerFile.sv
  - hdl/decodeUnit.sv
  - hdl/executeUnit.sv
  - hdl/retireStage.sv
  - hdl/pipeCore.sv
  - target: test
    files:
      - tests/pipeCore_properties.sv
      - tests/pipeCoreTb.sv

//--- compile.f
hdl/isaPkg.sv
hdl/corePkg.sv
hdl/registerFile.sv
hdl/decodeUnit.sv
hdl/executeUnit.sv
hdl/retireStage.sv
hdl/pipeCore.sv
tests/pipeCore_properties.sv
tests/pipeCoreTb.sv

//--- hdl/corePkg.sv
// pipeline control encodings; the ALU only adds, xors and and-nots and subtracts via invert plus carry-in
package corePkg;

  // operation picked in execute
  typedef enum logic [1:0] {
    AluAdd  = 2'b00, // a + b + cin, a optionally inverted
    AluXor  = 2'b01,
    AluAndn = 2'b10
  } aluOpT;

  // second operand source
  // anything other than ImmNone replaces the Rt operand
  typedef enum logic [1:0] {
    ImmNone  = 2'b00, // forwarded Rt
    ImmSext5 = 2'b01,
    ImmZext5 = 2'b10,
    ImmSext8 = 2'b11  // LBI with operand A forced to zero
  } immSelT;

endpackage

//--- hdl/decodeUnit.sv
// IF/ID and ID/EX registers around decode; undecoded opcodes and NOP leave exWrite low
`timescale 1ns/100ps

module decodeUnit (
  input  logic               clk,
  input  logic               reset,
  input  logic               instrValid,
  input  logic [15:0]        instr,
  input  logic               wbWrite,
  input  logic [2:0]         wbReg,
  input  logic [15:0]        wbData,
  output logic               exWrite,
  output logic [2:0]         exDest,
  output logic [2:0]         exRs,
  output logic [2:0]         exRt,
  output logic [15:0]        exOpA,
  output logic [15:0]        exOpB,
  output logic [15:0]        exImm,
  output corePkg::immSelT    exImmSel,
  output corePkg::aluOpT     exAluOp,
  output logic               exInvA,
  output logic               exCin
);

  logic               ifValid;
  logic [15:0]        ifInstr;
  isaPkg::opcodeT     opcode;
  isaPkg::functT      funct;
  logic [2:0]         rs;
  logic [2:0]         rt;
  logic [2:0]         rd;
  logic               decWrite;
  logic [2:0]         decDest;
  corePkg::aluOpT     decAluOp;
  corePkg::immSelT    decImmSel;
  logic               decInvA;
  logic               decCin;
  logic [15:0]        decImm;
  logic [15:0]        readA;
  logic [15:0]        readB;

  // IF/ID
  always_ff @(posedge clk) begin
    if (reset) ifValid <= 1'b0;
    else       ifValid <= instrValid;
    ifInstr <= instr;
  end

  assign opcode = isaPkg::opcodeT'(ifInstr[15:11]);
  assign funct  = isaPkg::functT'(ifInstr[1:0]);
  assign rs     = ifInstr[isaPkg::RsMsb -: isaPkg::RegAddrWidth];
  assign rt     = ifInstr[isaPkg::RtMsb -: isaPkg::RegAddrWidth];
  assign rd     = ifInstr[isaPkg::RdMsb -: isaPkg::RegAddrWidth];

  always_comb begin
    decWrite  = 1'b0;
    decDest   = rd;
    decAluOp  = corePkg::AluAdd;
    decImmSel = corePkg::ImmNone;
    decInvA   = 1'b0;
    decCin    = 1'b0;
    case (opcode)
      isaPkg::OpAlu: begin
        decWrite = 1'b1;
        case (funct)
          isaPkg::FnSub:  {decInvA, decCin} = 2'b11; // Rt - Rs
          isaPkg::FnXor:  decAluOp = corePkg::AluXor;
          isaPkg::FnAndn: decAluOp = corePkg::AluAndn;
          default:        decAluOp = corePkg::AluAdd;
        endcase
      end
      isaPkg::OpAddi: begin
        decWrite  = 1'b1;
        decDest   = rt; // I-format writes the Rt slot
        decImmSel = corePkg::ImmSext5;
      end
      isaPkg::OpSubi: begin
        decWrite  = 1'b1;
        decDest   = rt;
        decImmSel = corePkg::ImmSext5;
        decInvA   = 1'b1;
        decCin    = 1'b1;
      end
      isaPkg::OpXori: begin
        decWrite  = 1'b1;
        decDest   = rt;
        decImmSel = corePkg::ImmZext5;
        decAluOp  = corePkg::AluXor;
      end
      isaPkg::OpLbi: begin
        decWrite  = 1'b1;
        decDest   = rs; // LBI names its target in the Rs slot
        decImmSel = corePkg::ImmSext8;
      end
      default: decWrite = 1'b0; // NOP and anything undecoded
    endcase
  end

  always_comb begin
    case (decImmSel)
      corePkg::ImmSext5: decImm = {{(isaPkg::DataWidth - 5){ifInstr[4]}}, ifInstr[4:0]};
      corePkg::ImmZext5: decImm = {{(isaPkg::DataWidth - 5){1'b0}}, ifInstr[4:0]};
      corePkg::ImmSext8: decImm = {{(isaPkg::DataWidth - 8){ifInstr[7]}}, ifInstr[7:0]};
      default:           decImm = '0;
    endcase
  end

  registerFile regFile_inst (
    .clk       (clk),
    .reset     (reset),
    .readRegA  (rs),
    .readRegB  (rt),
    .readDataA (readA),
    .readDataB (readB),
    .writeEn   (wbWrite),
    .writeReg  (wbReg),
    .writeData (wbData)
  );

  // ID/EX
  always_ff @(posedge clk) begin
    if (reset) exWrite <= 1'b0;
    else       exWrite <= ifValid & decWrite;
  end

  always_ff @(posedge clk) begin
    exDest   <= decDest;
    exRs     <= rs;
    exRt     <= rt;
    exOpA    <= readA;
    exOpB    <= readB;
    exImm    <= decImm;
    exImmSel <= decImmSel;
    exAluOp  <= decAluOp;
    exInvA   <= decInvA;
    exCin    <= decCin;
  end

endmodule

//--- hdl/executeUnit.sv
// forwarding and ALU; EX/MEM wins over MEM/WB on a match and valid bits of writers gate every bypass
`timescale 1ns/100ps

module executeUnit (
  input  logic               clk,
  input  logic               reset,
  input  logic               exWrite,
  input  logic [2:0]         exDest,
  input  logic [2:0]         exRs,
  input  logic [2:0]         exRt,
  input  logic [15:0]        exOpA,
  input  logic [15:0]        exOpB,
  input  logic [15:0]        exImm,
  input  corePkg::immSelT    exImmSel,
  input  corePkg::aluOpT     exAluOp,
  input  logic               exInvA,
  input  logic               exCin,
  output logic               memWrite,
  output logic [2:0]         memDest,
  output logic [15:0]        memData,
  input  logic               wbWrite,
  input  logic [2:0]         wbReg,
  input  logic [15:0]        wbData
);

  logic [15:0] fwdA;
  logic [15:0] fwdB;
  logic [15:0] aluA;
  logic [15:0] aluB;
  logic [15:0] result;

  // youngest writer first
  always_comb begin
    if (memWrite && (memDest == exRs))     fwdA = memData;
    else if (wbWrite && (wbReg == exRs))   fwdA = wbData;
    else                                   fwdA = exOpA;
    if (memWrite && (memDest == exRt))     fwdB = memData;
    else if (wbWrite && (wbReg == exRt))   fwdB = wbData;
    else                                   fwdB = exOpB;
  end

  // LBI adds its immediate to zero
  assign aluA = (exImmSel == corePkg::ImmSext8) ? 16'h0000 : fwdA;
  assign aluB = (exImmSel == corePkg::ImmNone)  ? fwdB : exImm;

  always_comb begin
    case (exAluOp)
      corePkg::AluXor:  result = aluA ^ aluB;
      corePkg::AluAndn: result = aluA & ~aluB;
      default: begin
        // ~a + b + 1 gives b - a
        result = (exInvA ? ~aluA : aluA) + aluB + {15'b0, exCin};
      end
    endcase
  end

  // EX/MEM
  always_ff @(posedge clk) begin
    if (reset) memWrite <= 1'b0;
    else       memWrite <= exWrite;
    memDest <= exDest;
    memData <= result;
  end

endmodule

//--- hdl/isaPkg.sv
// 16-bit instruction encoding; only the opcodes kept by this core are listed and others retire nothing
package isaPkg;

  localparam int DataWidth    = 16;
  localparam int RegAddrWidth = 3;
  localparam int NumRegs      = 8;

  // register field positions, msb of each 3-bit field
  localparam int RsMsb = 10; // bits 10:8
  localparam int RtMsb = 7;  // bits 7:5 and the I-format destination
  localparam int RdMsb = 4;  // bits 4:2 as R-format destination

  // major opcode in bits 15:11
  typedef enum logic [4:0] {
    OpNop  = 5'b00001,
    OpAddi = 5'b01000, // Rd <- Rs + sext(imm5)
    OpSubi = 5'b01001, // Rd <- sext(imm5) - Rs
    OpXori = 5'b01010, // Rd <- Rs ^ zext(imm5)
    OpLbi  = 5'b11000, // Rs <- sext(imm8)
    OpAlu  = 5'b11011  // R-format with function in bits 1:0
  } opcodeT;

  // R-format function field
  typedef enum logic [1:0] {
    FnAdd  = 2'b00, // Rs + Rt
    FnSub  = 2'b01, // Rt - Rs
    FnXor  = 2'b10,
    FnAndn = 2'b11  // Rs & ~Rt
  } functT;

endpackage

//--- hdl/pipeCore.sv
// top level; one instruction per clock with no back-pressure, a writing instruction retires 4 cycles later
`timescale 1ns/100ps

module pipeCore (
  input  logic        clk,
  input  logic        reset,
  input  logic        instrValid,
  input  logic [15:0] instr,
  output logic        wbValid,
  output logic [2:0]  wbReg,
  output logic [15:0] wbData
);

  logic               exWrite;
  logic [2:0]         exDest;
  logic [2:0]         exRs;
  logic [2:0]         exRt;
  logic [15:0]        exOpA;
  logic [15:0]        exOpB;
  logic [15:0]        exImm;
  corePkg::immSelT    exImmSel;
  corePkg::aluOpT     exAluOp;
  logic               exInvA;
  logic               exCin;
  logic               memWrite;
  logic [2:0]         memDest;
  logic [15:0]        memData;

  // MEM/WB goes back into the register file
  decodeUnit decodeUnit_inst (
    .clk        (clk),
    .reset      (reset),
    .instrValid (instrValid),
    .instr      (instr),
    .wbWrite    (wbValid),
    .wbReg      (wbReg),
    .wbData     (wbData),
    .exWrite    (exWrite),
    .exDest     (exDest),
    .exRs       (exRs),
    .exRt       (exRt),
    .exOpA      (exOpA),
    .exOpB      (exOpB),
    .exImm      (exImm),
    .exImmSel   (exImmSel),
    .exAluOp    (exAluOp),
    .exInvA     (exInvA),
    .exCin      (exCin)
  );

  executeUnit executeUnit_inst (
    .clk      (clk),
    .reset    (reset),
    .exWrite  (exWrite),
    .exDest   (exDest),
    .exRs     (exRs),
    .exRt     (exRt),
    .exOpA    (exOpA),
    .exOpB    (exOpB),
    .exImm    (exImm),
    .exImmSel (exImmSel),
    .exAluOp  (exAluOp),
    .exInvA   (exInvA),
    .exCin    (exCin),
    .memWrite (memWrite), // EX/MEM tap loops back for forwarding
    .memDest  (memDest),
    .memData  (memData),
    .wbWrite  (wbValid),  // MEM/WB tap
    .wbReg    (wbReg),
    .wbData   (wbData)
  );

  retireStage retireStage_inst (
    .clk      (clk),
    .reset    (reset),
    .memWrite (memWrite),
    .memDest  (memDest),
    .memData  (memData),
    .wbWrite  (wbValid),
    .wbReg    (wbReg),
    .wbData   (wbData)
  );

endmodule

//--- hdl/registerFile.sv
// eight 16-bit registers, cleared on reset; a same-cycle write is visible on both read ports
`timescale 1ns/100ps

module registerFile (
  input  logic        clk,
  input  logic        reset,
  input  logic [2:0]  readRegA,
  input  logic [2:0]  readRegB,
  output logic [15:0] readDataA,
  output logic [15:0] readDataB,
  input  logic        writeEn,
  input  logic [2:0]  writeReg,
  input  logic [15:0] writeData
);

  logic [15:0] regs [8];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn) begin
      regs[writeReg] <= writeData;
    end
  end

  // write-through covers the instruction three behind the writer
  always_comb begin
    if (writeEn && (writeReg == readRegA)) begin
      readDataA = writeData;
    end else begin
      readDataA = regs[readRegA];
    end
  end

  always_comb begin
    if (writeEn && (writeReg == readRegB)) begin
      readDataB = writeData;
    end else begin
      readDataB = regs[readRegB];
    end
  end

endmodule

//--- hdl/retireStage.sv
// MEM/WB register at the memory position; no data memory, the EX/MEM value passes on unchanged
`timescale 1ns/100ps

module retireStage (
  input  logic        clk,
  input  logic        reset,
  input  logic        memWrite,
  input  logic [2:0]  memDest,
  input  logic [15:0] memData,
  output logic        wbWrite,
  output logic [2:0]  wbReg,
  output logic [15:0] wbData
);

  // valid bit
  always_ff @(posedge clk) begin
    if (reset) begin
      wbWrite <= 1'b0;
    end else begin
      wbWrite <= memWrite;
    end
  end

  always_ff @(posedge clk) begin
    wbReg  <= memDest;
    wbData <= memData; // alu result
  end

endmodule

//--- tests/pipeCoreTb.sv
// fixed instruction table with hand-computed writebacks; random idle gaps only where a row allows them
`timescale 1ns/100ps

module pipeCoreTb;

  localparam int ClkPeriod   = 8;
  localparam int ResetCycles = 10;
  localparam int MaxIdle     = 3; // idle cycles per gap at most
  localparam int Latency     = 4;

  typedef struct {
    logic [15:0] word;
    bit          retires;
    logic [2:0]  dest;
    logic [15:0] value;
    bit          idleOk; // gap allowed before this row
  } rowT;

  typedef struct {
    logic [2:0]  dest;
    logic [15:0] value;
    int          cycle;
    int          row;
  } expT;

  logic        clk;
  logic        reset;
  logic        instrValid;
  logic [15:0] instr;
  logic        wbValid;
  logic [2:0]  wbReg;
  logic [15:0] wbData;

  rowT stimRows[$];
  expT expQ[$];
  int  cycle = 0;
  int  checked = 0;
  int  valueErrors = 0;
  int  protocolErrors = 0;
  bit  tableReady = 1'b0;

  pipeCore pipeCore_inst (
    .clk        (clk),
    .reset      (reset),
    .instrValid (instrValid),
    .instr      (instr),
    .wbValid    (wbValid),
    .wbReg      (wbReg),
    .wbData     (wbData)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  always @(posedge clk) cycle <= cycle + 1;

  function automatic logic [15:0] lbiWord(input logic [2:0] rs, input logic [7:0] imm8);
    return {isaPkg::OpLbi, rs, imm8};
  endfunction

  function automatic logic [15:0] aluWord(input logic [2:0] rs, input logic [2:0] rt,
                                          input logic [2:0] rd, input isaPkg::functT fn);
    return {isaPkg::OpAlu, rs, rt, rd, fn};
  endfunction

  function automatic logic [15:0] immWord(input isaPkg::opcodeT op, input logic [2:0] rs,
                                          input logic [2:0] rt, input logic [4:0] imm5);
    return {op, rs, rt, imm5};
  endfunction

  function automatic int assertionErrors();
    return pipeCore_inst.pipeCoreProperties_inst.failCount;
  endfunction

  task automatic addRow(input logic [15:0] word, input bit retires, input logic [2:0] dest,
                        input logic [15:0] value, input bit idleOk);
    rowT r;
    r.word    = word;
    r.retires = retires;
    r.dest    = dest;
    r.value   = value;
    r.idleOk  = idleOk;
    stimRows.push_back(r);
  endtask

  task automatic buildTable();
    // LBI of positive and negative values into every register
    addRow(lbiWord(3'd0, 8'h12), 1, 3'd0, 16'h0012, 1);
    addRow(lbiWord(3'd1, 8'h85), 1, 3'd1, 16'hFF85, 1);
    addRow(lbiWord(3'd2, 8'h7F), 1, 3'd2, 16'h007F, 1);
    addRow(lbiWord(3'd3, 8'hF0), 1, 3'd3, 16'hFFF0, 1);
    addRow(lbiWord(3'd4, 8'h33), 1, 3'd4, 16'h0033, 1);
    addRow(lbiWord(3'd5, 8'h80), 1, 3'd5, 16'hFF80, 1);
    addRow(lbiWord(3'd6, 8'h01), 1, 3'd6, 16'h0001, 1);
    addRow(lbiWord(3'd7, 8'hFF), 1, 3'd7, 16'hFFFF, 1);
    // R-format with gaps
    addRow(aluWord(3'd2, 3'd4, 3'd0, isaPkg::FnAdd), 1, 3'd0, 16'h00B2, 1);
    addRow(aluWord(3'd6, 3'd3, 3'd6, isaPkg::FnSub), 1, 3'd6, 16'hFFEF, 1);  // rt - rs
    addRow(aluWord(3'd1, 3'd2, 3'd5, isaPkg::FnXor), 1, 3'd5, 16'hFFFA, 1);
    addRow(aluWord(3'd7, 3'd3, 3'd4, isaPkg::FnAndn), 1, 3'd4, 16'h000F, 1);
    // I-format with destination in the rt slot
    addRow(immWord(isaPkg::OpAddi, 3'd2, 3'd1, 5'b11100), 1, 3'd1, 16'h007B, 1);
    addRow(immWord(isaPkg::OpSubi, 3'd3, 3'd2, 5'b00011), 1, 3'd2, 16'h0013, 1);
    addRow(immWord(isaPkg::OpSubi, 3'd6, 3'd0, 5'b10000), 1, 3'd0, 16'h0001, 1);
    addRow(immWord(isaPkg::OpXori, 3'd5, 3'd5, 5'b11111), 1, 3'd5, 16'hFFE5, 1);
    // distance 1 from EX/MEM
    addRow(lbiWord(3'd3, 8'h10), 1, 3'd3, 16'h0010, 1);
    addRow(aluWord(3'd3, 3'd3, 3'd4, isaPkg::FnAdd), 1, 3'd4, 16'h0020, 0);
    addRow(aluWord(3'd1, 3'd4, 3'd5, isaPkg::FnSub), 1, 3'd5, 16'hFFA5, 0);
    addRow(immWord(isaPkg::OpXori, 3'd5, 3'd5, 5'b01010), 1, 3'd5, 16'hFFAF, 0);
    // distance 2 from MEM/WB
    addRow(lbiWord(3'd0, 8'h40), 1, 3'd0, 16'h0040, 1);
    addRow(lbiWord(3'd1, 8'hC0), 1, 3'd1, 16'hFFC0, 0);
    addRow(aluWord(3'd0, 3'd5, 3'd6, isaPkg::FnAndn), 1, 3'd6, 16'h0040, 0);
    addRow(immWord(isaPkg::OpAddi, 3'd1, 3'd2, 5'b00111), 1, 3'd2, 16'hFFC7, 0);
    // distance 3 through register file write-through
    addRow(lbiWord(3'd7, 8'h25), 1, 3'd7, 16'h0025, 1);
    addRow(lbiWord(3'd0, 8'h01), 1, 3'd0, 16'h0001, 0);
    addRow(lbiWord(3'd1, 8'h02), 1, 3'd1, 16'h0002, 0);
    addRow(immWord(isaPkg::OpAddi, 3'd7, 3'd3, 5'b00001), 1, 3'd3, 16'h0026, 0);
    addRow(aluWord(3'd0, 3'd1, 3'd4, isaPkg::FnSub), 1, 3'd4, 16'h0001, 0);
    // three writers to r2 in flight and the youngest wins
    addRow(lbiWord(3'd2, 8'h11), 1, 3'd2, 16'h0011, 1);
    addRow(lbiWord(3'd2, 8'h22), 1, 3'd2, 16'h0022, 0);
    addRow(lbiWord(3'd2, 8'h33), 1, 3'd2, 16'h0033, 0);
    addRow(aluWord(3'd2, 3'd2, 3'd5, isaPkg::FnAdd), 1, 3'd5, 16'h0066, 0);
    // NOP and undecoded opcodes mixed in
    addRow(lbiWord(3'd6, 8'h07), 1, 3'd6, 16'h0007, 1);
    addRow({5'b00001, 11'h000}, 0, 3'd0, 16'h0000, 0);
    addRow({5'b10000, 3'd6, 3'd6, 5'd0}, 0, 3'd0, 16'h0000, 0);
    addRow(immWord(isaPkg::OpAddi, 3'd6, 3'd6, 5'b00010), 1, 3'd6, 16'h0009, 0);
    addRow({5'b00000, 3'd6, 3'd0, 5'd0}, 0, 3'd0, 16'h0000, 0);
    addRow(aluWord(3'd6, 3'd5, 3'd0, isaPkg::FnXor), 1, 3'd0, 16'h006F, 0);
    addRow(16'hFFFF, 0, 3'd0, 16'h0000, 0);
    addRow(immWord(isaPkg::OpSubi, 3'd0, 3'd1, 5'b00000), 1, 3'd1, 16'hFF91, 0);
  endtask

  task automatic reportCounts();
    $display("checked %0d, value errors %0d, protocol errors %0d, assertion errors %0d",
             checked, valueErrors, protocolErrors, assertionErrors());
  endtask

  // outputs sampled mid-cycle
  always @(negedge clk) begin : checkWb
    expT e;
    if (!reset && wbValid === 1'b1) begin
      if (expQ.size() == 0) begin
        $display("writeback to register %0d at cycle %0d with no instruction pending",
                 wbReg, cycle);
        protocolErrors++;
      end else begin
        e = expQ.pop_front();
        checked++;
        if (cycle != e.cycle) begin
          $display("row %0d retired at cycle %0d but was due at cycle %0d",
                   e.row, cycle, e.cycle);
          protocolErrors++;
        end
        if (wbReg !== e.dest) begin
          $display("error: wbReg expected 0x%0h got 0x%0h (row %0d)", e.dest, wbReg, e.row);
          valueErrors++;
        end
        if (wbData !== e.value) begin
          $display("error: wbData expected 0x%04h got 0x%04h (row %0d)",
                   e.value, wbData, e.row);
          valueErrors++;
        end
      end
    end
  end

  initial begin : stimulus
    int  idle;
    expT e;
    reset      = 1'b1;
    instrValid = 1'b0;
    instr      = '0;
    void'($urandom(32'h8c082cdb));
    buildTable();
    tableReady = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    #1 reset = 1'b0;
    foreach (stimRows[i]) begin
      if (stimRows[i].idleOk) begin
        idle = $urandom_range(MaxIdle, 0);
        repeat (idle) begin
          @(posedge clk);
          #1;
          instrValid = 1'b0;
          instr      = 16'($urandom); // garbage while invalid
        end
      end
      @(posedge clk);
      #1;
      instrValid = 1'b1;
      instr      = stimRows[i].word;
      if (stimRows[i].retires) begin
        e.dest  = stimRows[i].dest;
        e.value = stimRows[i].value;
        e.cycle = cycle + Latency; // sampled at the next edge
        e.row   = i;
        expQ.push_back(e);
      end
    end
    @(posedge clk);
    #1 instrValid = 1'b0;
    repeat (Latency + 2) @(posedge clk);
    if (expQ.size() != 0) begin
      $display("%0d expected writebacks never appeared", expQ.size());
      protocolErrors += expQ.size();
    end
    reportCounts();
    if (valueErrors + protocolErrors + assertionErrors() == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin : watchdog
    int limit;
    wait (tableReady);
    limit = stimRows.size() * (1 + MaxIdle) + ResetCycles + 20;
    #(limit * ClkPeriod);
    $display("simulation did not finish within %0d cycles", limit);
    protocolErrors++;
    reportCounts();
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

//--- tests/pipeCore_properties.sv
// checks on the top-level ports only; assumes instrValid is driven low during reset
`timescale 1ns/100ps

module pipeCoreProperties (
  input logic                              clk,
  input logic                              reset,
  input logic                              instrValid,
  input logic                              wbValid,
  input logic [isaPkg::RegAddrWidth-1:0]   wbReg,
  input logic [isaPkg::DataWidth-1:0]      wbData
);

  int failCount = 0; // failed assertions so far

  // valid bits clear at the first reset edge and stay low one cycle past it
  noWbAroundReset: assert property (@(posedge clk)
    ($past(reset) || $past(reset, 2)) |-> !wbValid)
    else begin
      $error("wbValid high during or right after reset");
      failCount++;
    end

  // fixed four-cycle latency
  wbHasSource: assert property (@(posedge clk) disable iff (reset)
    wbValid |-> $past(instrValid, 4))
    else begin
      $error("wbValid without an instruction four cycles earlier");
      failCount++;
    end

  wbKnown: assert property (@(posedge clk) disable iff (reset)
    wbValid |-> !$isunknown({wbReg, wbData}))
    else begin
      $error("wbReg or wbData unknown while wbValid is high");
      failCount++;
    end

endmodule

bind pipeCore pipeCoreProperties pipeCoreProperties_inst (.*);
